// ==== dv/tb_clock.sv ====
`timescale 1ns/100ps

module tb_clock (
	output logic clk_sys,
	output logic arst_n
);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys; // 4 ns period
	end

	initial begin
		arst_n = 1'b0;
		repeat (5) @(posedge clk_sys);
		#1 arst_n = 1'b1;
	end

endmodule

// ==== dv/tb_iobus.sv ====
`timescale 1ns/100ps

module tb_iobus;

	localparam int CLKS_PER_BIT = 8;
	localparam int FRAME_CYCLES = 70 * CLKS_PER_BIT; // one frame with margin
	localparam int STEP_LIMIT = 2 * FRAME_CYCLES;
	localparam int NUM_FRAMES = 16;
	localparam int WATCHDOG_NS = NUM_FRAMES * FRAME_CYCLES * 4 * 3;

	logic              clk_sys;
	logic              arst_n;
	logic              rxd;
	logic              txd;
	logic              zg;
	logic              zw;
	iob_pkg::bus_in_t  bus_in;
	iob_pkg::bus_out_t bus_out;

	logic [7:0]  exp_q[$]; // bytes the bridge should send
	logic [7:0]  got_q[$]; // bytes seen on txd
	int          err_cnt = 0;
	int          fail_cnt = 0;
	logic [31:0] seed = 32'd64242;

	tb_clock u_clock (
		.clk_sys (clk_sys),
		.arst_n  (arst_n)
	);

	iobus #(
		.CLKS_PER_BIT(CLKS_PER_BIT)
	) dut (
		.clk_sys (clk_sys),
		.arst_n  (arst_n),
		.rxd     (rxd),
		.txd     (txd),
		.zg      (zg),
		.zw      (zw),
		.bus_in  (bus_in),
		.bus_out (bus_out)
	);

	function logic [15:0] lcg_next();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed[31:16];
	endfunction

	// frame layout, byte 0 in the top bits
	function automatic logic [47:0] encode_frame(iob_pkg::msg_t m);
		logic [47:0] f;
		f[47:40] = {m.is_req, 3'b000, m.cmd};
		f[39:32] = {m.qb, m.pn, 2'b00, m.nb};
		f[31:16] = m.ad; // high byte goes first
		f[15:0] = m.dt;
		return f;
	endfunction

	// what the bridge should show on the bus for a held message
	function automatic iob_pkg::bus_out_t expected_out(iob_pkg::msg_t m);
		iob_pkg::bus_out_t o;
		o = '0;
		if (m.is_req) begin
			case (m.cmd)
				iob_pkg::PA: o.pa = 1'b1;
				iob_pkg::W: o.w = 1'b1;
				iob_pkg::R: o.r = 1'b1;
				iob_pkg::IN: o.in = 1'b1;
				default: ;
			endcase
		end else begin
			case (m.cmd)
				iob_pkg::OK: o.ok = 1'b1;
				iob_pkg::PE: o.pe = 1'b1;
				iob_pkg::EN: o.en = 1'b1;
				default: ;
			endcase
		end
		o.pn = m.pn;
		o.nb = m.nb;
		o.ad = m.ad;
		o.dt = m.dt;
		return o;
	endfunction

	function automatic iob_pkg::bus_in_t bus_from_msg(iob_pkg::msg_t m);
		iob_pkg::bus_in_t b;
		b = '0;
		b.s = m.is_req & (m.cmd == iob_pkg::S);
		b.f = m.is_req & (m.cmd == iob_pkg::F);
		b.cl = m.is_req & (m.cmd == iob_pkg::CL);
		b.ok = !m.is_req & (m.cmd == iob_pkg::OK);
		b.pe = !m.is_req & (m.cmd == iob_pkg::PE);
		b.qb = m.qb;
		b.pn = m.pn;
		b.nb = m.nb;
		b.ad = m.ad;
		b.dt = m.dt;
		return b;
	endfunction

	function automatic iob_pkg::msg_t random_msg(logic is_req, logic [3:0] cmd);
		iob_pkg::msg_t m;
		logic [15:0]   r;
		r = lcg_next();
		m.is_req = is_req;
		m.cmd = cmd;
		m.qb = r[0];
		m.pn = r[1];
		m.nb = r[5:2];
		m.ad = lcg_next();
		m.dt = lcg_next();
		return m;
	endfunction

	function automatic logic has_strobe(iob_pkg::bus_out_t o);
		return o.pa | o.w | o.r | o.in | o.ok | o.en | o.pe;
	endfunction

	task automatic check_value(input string name, input logic [47:0] got,
		input logic [47:0] expected);
		if (got !== expected) begin
			$display("Error at time %0t: %s got %h expected %h", $time, name, got, expected);
			err_cnt++;
		end
	endtask

	task automatic report_failure(input string what);
		$display("Failure at time %0t: %s", $time, what);
		fail_cnt++;
	endtask

	task automatic print_counts();
		$display("Summary: %0d value errors, %0d other failures", err_cnt, fail_cnt);
	endtask

	task automatic drive_bus(input iob_pkg::bus_in_t v);
		@(posedge clk_sys);
		#1 bus_in = v;
	endtask

	task automatic drive_zw(input logic v);
		@(posedge clk_sys);
		#1 zw = v;
	endtask

	task automatic push_frame(input iob_pkg::msg_t m);
		logic [47:0] f;
		int          i;
		f = encode_frame(m);
		for (i = 0; i < iob_pkg::FRAME_BYTES; i++)
			exp_q.push_back(f[47 - 8 * i -: 8]);
	endtask

	task automatic drive_bit(input logic b);
		@(posedge clk_sys);
		#1 rxd = b;
		repeat (CLKS_PER_BIT - 1) @(posedge clk_sys);
	endtask

	// remote host puts one frame on rxd, 8N1
	task automatic host_send(input iob_pkg::msg_t m);
		logic [47:0] f;
		logic [7:0]  b;
		int          i;
		int          j;
		f = encode_frame(m);
		for (i = 0; i < iob_pkg::FRAME_BYTES; i++) begin
			b = f[47 - 8 * i -: 8];
			drive_bit(1'b0);
			for (j = 0; j < 8; j++)
				drive_bit(b[j]);
			drive_bit(1'b1);
		end
	endtask

	task automatic wait_tx_done();
		int n;
		n = 0;
		while (exp_q.size() != 0 && n < STEP_LIMIT) begin
			@(negedge clk_sys);
			n++;
		end
		if (exp_q.size() != 0)
			report_failure("expected frame never arrived");
	endtask

	task automatic wait_zg(input logic level);
		int n;
		n = 0;
		while (zg !== level && n < STEP_LIMIT) begin
			@(negedge clk_sys);
			n++;
		end
		if (zg !== level)
			report_failure(level ? "zg never rose" : "zg never fell");
	endtask

	task automatic wait_strobe(input string what);
		int n;
		n = 0;
		while (!has_strobe(bus_out) && n < STEP_LIMIT) begin
			@(negedge clk_sys);
			n++;
		end
		if (!has_strobe(bus_out))
			report_failure({"no strobe on bus_out while waiting for ", what});
	endtask

	task automatic wait_idle_out();
		int n;
		n = 0;
		while (bus_out !== '0 && n < STEP_LIMIT) begin
			@(negedge clk_sys);
			n++;
		end
		check_value("bus_out", 48'(bus_out), 48'(0));
	endtask

	// remote request already sent by the host
	task automatic serve_remote(input iob_pkg::msg_t req, input logic use_pe);
		iob_pkg::msg_t rsp;
		wait_zg(1'b1);
		repeat (4) begin
			@(negedge clk_sys);
			check_value("bus_out before zw", 48'(bus_out), 48'(0));
		end
		drive_zw(1'b1);
		wait_strobe("remote request");
		check_value("bus_out", 48'(bus_out), 48'(expected_out(req)));
		rsp = random_msg(1'b0, use_pe ? iob_pkg::PE : iob_pkg::OK);
		push_frame(rsp);
		drive_bus(bus_from_msg(rsp));
		wait_zg(1'b0);
		if (exp_q.size() != 0)
			report_failure("zg fell before the response frame was sent");
		check_value("bus_out after release", 48'(bus_out), 48'(0));
		drive_bus('0);
		drive_zw(1'b0);
	endtask

	task automatic local_with_reply(input logic use_f);
		iob_pkg::msg_t req;
		iob_pkg::msg_t rsp;
		req = random_msg(1'b1, use_f ? iob_pkg::F : iob_pkg::S);
		push_frame(req);
		drive_bus(bus_from_msg(req));
		wait_tx_done();
		rsp = random_msg(1'b0, iob_pkg::OK);
		host_send(rsp);
		wait_strobe("ok");
		check_value("bus_out", 48'(bus_out), 48'(expected_out(rsp)));
		drive_bus('0);
		wait_idle_out();
	endtask

	task automatic local_clear();
		iob_pkg::msg_t req;
		req = random_msg(1'b1, iob_pkg::CL);
		push_frame(req);
		drive_bus(bus_from_msg(req));
		wait_tx_done();
		repeat (10) begin
			@(negedge clk_sys);
			check_value("bus_out after cl", 48'(bus_out), 48'(0));
		end
		drive_bus('0);
	endtask

	task automatic remote_pass();
		iob_pkg::msg_t req;
		req = random_msg(1'b1, iob_pkg::PA);
		fork
			host_send(req);
			begin
				wait_strobe("pa");
				check_value("bus_out", 48'(bus_out), 48'(expected_out(req)));
				check_value("zg during pa", 48'(zg), 48'(0));
			end
		join
		repeat (FRAME_CYCLES) @(negedge clk_sys); // any frame would show up here
		check_value("zg after pa", 48'(zg), 48'(0));
		check_value("bus_out after pa", 48'(bus_out), 48'(0));
	endtask

	task automatic collision();
		iob_pkg::msg_t     req;
		iob_pkg::msg_t     rem;
		iob_pkg::bus_out_t en_only;
		en_only = '0;
		en_only.en = 1'b1;
		req = random_msg(1'b1, iob_pkg::S);
		push_frame(req);
		drive_bus(bus_from_msg(req));
		wait_tx_done();
		rem = random_msg(1'b1, iob_pkg::W);
		host_send(rem); // zw still low
		wait_strobe("en");
		check_value("bus_out during collision", 48'(bus_out), 48'(en_only));
		drive_bus('0);
		serve_remote(rem, 1'b0);
	endtask

	// decode txd, sampled near the middle of each bit
	initial begin : txd_monitor
		logic [7:0] b;
		int         i;
		forever begin
			@(negedge clk_sys);
			if (arst_n && txd === 1'b0) begin
				repeat (CLKS_PER_BIT / 2 - 1) @(negedge clk_sys);
				for (i = 0; i < 8; i++) begin
					repeat (CLKS_PER_BIT) @(negedge clk_sys);
					b[i] = txd;
				end
				repeat (CLKS_PER_BIT) @(negedge clk_sys);
				if (txd !== 1'b1)
					report_failure("stop bit missing on txd");
				got_q.push_back(b);
			end
		end
	end

	initial begin : frame_compare
		logic [7:0] got;
		forever begin
			@(posedge clk_sys);
			while (got_q.size() != 0) begin
				got = got_q.pop_front();
				if (exp_q.size() == 0)
					report_failure("unexpected byte on txd");
				else
					check_value("txd byte", 48'(got), 48'(exp_q.pop_front()));
			end
		end
	end

	initial begin : watchdog
		#(WATCHDOG_NS);
		report_failure("watchdog timeout, run did not complete");
		print_counts();
		$display("Testbench failed");
		$finish;
	end

	initial begin
		bus_in = '0;
		zw = 1'b0;
		rxd = 1'b1; // uart idle
		@(posedge arst_n);
		@(negedge clk_sys);
		check_value("txd", 48'(txd), 48'(1));
		check_value("zg", 48'(zg), 48'(0));
		check_value("bus_out", 48'(bus_out), 48'(0));

		local_with_reply(1'b0);
		local_clear();
		local_with_reply(1'b1);   // new request right after cl
		remote_request_all();
		remote_pass();
		collision();

		repeat (20) @(negedge clk_sys);
		if (exp_q.size() != 0)
			report_failure("expected frame never arrived");
		print_counts();
		if (err_cnt == 0 && fail_cnt == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

	task automatic remote_request_all();
		iob_pkg::msg_t req;
		req = random_msg(1'b1, iob_pkg::W);
		host_send(req);
		serve_remote(req, 1'b0);
		req = random_msg(1'b1, iob_pkg::R);
		host_send(req);
		serve_remote(req, 1'b1); // reply with pe
		req = random_msg(1'b1, iob_pkg::IN);
		host_send(req);
		serve_remote(req, 1'b0);
	endtask

endmodule

// ==== list.f ====
logic/iob_pkg.sv
logic/uart_link.sv
logic/msg_tx.sv
logic/msg_rx.sv
logic/iob_ctrl.sv
logic/iobus.sv
dv/tb_clock.sv
dv/tb_iobus.sv

// ==== logic/iob_ctrl.sv ====
`timescale 1ns/100ps

module iob_ctrl (
	input  logic              clk_sys,
	input  logic              arst_n,
	input  iob_pkg::bus_in_t  bus,
	input  iob_pkg::msg_t     msg,
	input  logic              cmd_ready,
	input  logic              rx_busy,
	output logic              release_cmd,
	output logic              send,
	input  logic              tx_busy,
	output logic              zg,
	input  logic              zw,
	output iob_pkg::bus_out_t bus_out
);

	typedef enum logic [2:0] {
		IDLE,
		R_REQ,
		D_RESP,
		D_REQ,
		R_RESP,
		D_EN,
		WAIT
	} ctrl_state_e;

	ctrl_state_e state;
	logic        d_ena; // drive enable
	logic        r_req;
	logic        r_resp;
	logic        d_req;
	logic        d_resp;

	assign r_req = bus.s | bus.f | bus.cl;
	assign r_resp = bus.ok | bus.pe;
	assign d_req = cmd_ready & msg.is_req & ~release_cmd;
	assign d_resp = cmd_ready & ~msg.is_req & ~release_cmd;

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			state <= IDLE;
			d_ena <= 1'b0;
			zg <= 1'b0;
			send <= 1'b0;
			release_cmd <= 1'b0;
		end else begin
			send <= 1'b0;
			release_cmd <= 1'b0;
			case (state)
				IDLE: if (r_req) begin
					if (!tx_busy) begin // local request
						send <= 1'b1;
						state <= bus.cl ? D_RESP : R_REQ; // CL has no reply
					end
				end else if (d_req) begin
					if (msg.cmd == iob_pkg::PA) begin
						d_ena <= 1'b1; // interrupt passes straight through
						state <= WAIT;
					end else begin
						zg <= 1'b1;
						state <= D_REQ;
					end
				end
				R_REQ: if (d_resp && !rx_busy) begin
					d_ena <= 1'b1;
					state <= D_RESP;
				end else if (!zw && d_req && !rx_busy) begin
					state <= D_EN; // collision
				end
				D_RESP: if (!r_req) begin
					d_ena <= 1'b0;
					release_cmd <= d_ena; // nothing held after CL
					state <= IDLE;
				end
				D_REQ: if (zw && !rx_busy) begin
					d_ena <= 1'b1;
					state <= R_RESP;
				end
				R_RESP: if (r_resp) begin
					send <= 1'b1;
					state <= WAIT;
				end
				D_EN: if (!r_req) begin
					zg <= 1'b1;
					state <= D_REQ;
				end
				default: if (!send && !tx_busy) begin // reply frame out
					zg <= 1'b0;
					d_ena <= 1'b0;
					release_cmd <= 1'b1;
					state <= IDLE;
				end
			endcase
		end
	end

	always_comb begin
		bus_out.pa = d_ena & msg.is_req & (msg.cmd == iob_pkg::PA);
		bus_out.w = d_ena & msg.is_req & (msg.cmd == iob_pkg::W);
		bus_out.r = d_ena & msg.is_req & (msg.cmd == iob_pkg::R);
		bus_out.in = d_ena & msg.is_req & (msg.cmd == iob_pkg::IN);
		bus_out.ok = d_ena & ~msg.is_req & (msg.cmd == iob_pkg::OK);
		bus_out.pe = d_ena & ~msg.is_req & (msg.cmd == iob_pkg::PE);
		bus_out.en = (d_ena & ~msg.is_req & (msg.cmd == iob_pkg::EN)) | (state == D_EN);
		bus_out.pn = d_ena ? msg.pn : 1'b0;
		bus_out.nb = d_ena ? msg.nb : 4'd0;
		bus_out.ad = d_ena ? msg.ad : 16'd0;
		bus_out.dt = d_ena ? msg.dt : 16'd0;
	end

endmodule

// ==== logic/iob_pkg.sv ====
package iob_pkg;

	localparam int FRAME_BYTES = 6;

	// commands carried in a request frame
	typedef enum logic [3:0] {
		PA = 4'd0, // pass interrupt
		CL = 4'd1, // clear, no reply
		W  = 4'd2,
		R  = 4'd3,
		S  = 4'd4,
		F  = 4'd5,
		IN = 4'd6
	} req_cmd_e;

	// commands carried in a response frame
	typedef enum logic [3:0] {
		EN = 4'd1, // engaged
		OK = 4'd2,
		PE = 4'd3  // parity error
	} resp_cmd_e;

	typedef struct packed {
		logic        is_req; // 1 request, 0 response
		logic [3:0]  cmd;    // req_cmd_e or resp_cmd_e
		logic        qb;
		logic        pn;
		logic [3:0]  nb;     // block number
		logic [15:0] ad;
		logic [15:0] dt;
	} msg_t;

	typedef struct packed {
		logic        s;
		logic        f;
		logic        cl;
		logic        ok;
		logic        pe;
		logic        qb;
		logic        pn;
		logic [3:0]  nb;
		logic [15:0] ad;
		logic [15:0] dt;
	} bus_in_t;

	typedef struct packed {
		logic        pa;
		logic        w;
		logic        r;
		logic        in;
		logic        ok;
		logic        en;
		logic        pe;
		logic        pn;
		logic [3:0]  nb;
		logic [15:0] ad;
		logic [15:0] dt;
	} bus_out_t;

endpackage

// ==== logic/iobus.sv ====
`timescale 1ns/100ps

module iobus #(
	parameter int CLKS_PER_BIT = 8
) (
	input  logic              clk_sys,
	input  logic              arst_n,
	input  logic              rxd,
	output logic              txd,
	output logic              zg,
	input  logic              zw,
	input  iob_pkg::bus_in_t  bus_in,
	output iob_pkg::bus_out_t bus_out
);

	logic [7:0]    tx_byte;
	logic          tx_send;
	logic          uart_tx_busy; // byte level
	logic [7:0]    rx_byte;
	logic          rx_valid;
	logic          msg_send;
	logic          msg_tx_busy;  // frame level
	iob_pkg::msg_t rx_msg;
	logic          cmd_ready;
	logic          rx_busy;
	logic          release_cmd;

	uart_link #(
		.CLKS_PER_BIT(CLKS_PER_BIT)
	) u_uart (
		.clk_sys  (clk_sys),
		.arst_n   (arst_n),
		.rxd      (rxd),
		.txd      (txd),
		.tx_byte  (tx_byte),
		.tx_send  (tx_send),
		.tx_busy  (uart_tx_busy),
		.rx_byte  (rx_byte),
		.rx_valid (rx_valid)
	);

	msg_tx u_msg_tx (
		.clk_sys (clk_sys),
		.arst_n  (arst_n),
		.send    (msg_send),
		.busy    (msg_tx_busy),
		.bus     (bus_in),
		.tx_byte (tx_byte),
		.tx_send (tx_send),
		.tx_busy (uart_tx_busy)
	);

	msg_rx u_msg_rx (
		.clk_sys     (clk_sys),
		.arst_n      (arst_n),
		.rx_byte     (rx_byte),
		.rx_valid    (rx_valid),
		.release_cmd (release_cmd),
		.msg         (rx_msg),
		.cmd_ready   (cmd_ready),
		.busy        (rx_busy)
	);

	iob_ctrl u_ctrl (
		.clk_sys     (clk_sys),
		.arst_n      (arst_n),
		.bus         (bus_in),
		.msg         (rx_msg),
		.cmd_ready   (cmd_ready),
		.rx_busy     (rx_busy),
		.release_cmd (release_cmd),
		.send        (msg_send),
		.tx_busy     (msg_tx_busy),
		.zg          (zg),
		.zw          (zw),
		.bus_out     (bus_out)
	);

endmodule

// ==== logic/msg_rx.sv ====
`timescale 1ns/100ps

module msg_rx (
	input  logic          clk_sys,
	input  logic          arst_n,
	input  logic [7:0]    rx_byte,
	input  logic          rx_valid,
	input  logic          release_cmd,
	output iob_pkg::msg_t msg,
	output logic          cmd_ready,
	output logic          busy
);

	logic [2:0] cnt; // next byte slot
	logic       take;

	assign take = rx_valid & ~cmd_ready; // drop bytes while holding

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			cnt <= '0;
			cmd_ready <= 1'b0;
			busy <= 1'b0;
		end else begin
			if (release_cmd)
				cmd_ready <= 1'b0;
			if (take) begin
				if (cnt == 3'(iob_pkg::FRAME_BYTES - 1)) begin
					cnt <= '0;
					busy <= 1'b0;
					cmd_ready <= 1'b1; // frame complete
				end else begin
					cnt <= cnt + 3'd1;
					busy <= 1'b1;
				end
			end
		end
	end

	// place bytes by frame layout
	always_ff @(posedge clk_sys) begin
		if (take) begin
			case (cnt)
				3'd0: begin
					msg.is_req <= rx_byte[7];
					msg.cmd <= rx_byte[3:0];
				end
				3'd1: begin
					msg.qb <= rx_byte[7];
					msg.pn <= rx_byte[6];
					msg.nb <= rx_byte[3:0];
				end
				3'd2: msg.ad[15:8] <= rx_byte;
				3'd3: msg.ad[7:0] <= rx_byte;
				3'd4: msg.dt[15:8] <= rx_byte;
				default: msg.dt[7:0] <= rx_byte;
			endcase
		end
	end

endmodule

// ==== logic/msg_tx.sv ====
`timescale 1ns/100ps

module msg_tx (
	input  logic            clk_sys,
	input  logic            arst_n,
	input  logic            send,
	output logic            busy,
	input  iob_pkg::bus_in_t bus,
	output logic [7:0]      tx_byte,
	output logic            tx_send,
	input  logic            tx_busy
);

	typedef enum logic [1:0] {
		TX_IDLE,
		TX_LOAD,
		TX_WAIT
	} tx_state_e;

	tx_state_e     state;
	logic [2:0]    idx; // byte in frame
	iob_pkg::msg_t msg;
	iob_pkg::msg_t bus_msg;

	always_comb begin
		bus_msg.is_req = bus.cl | bus.s | bus.f;
		if (bus.cl)
			bus_msg.cmd = iob_pkg::CL;
		else if (bus.s)
			bus_msg.cmd = iob_pkg::S;
		else if (bus.f)
			bus_msg.cmd = iob_pkg::F;
		else if (bus.ok)
			bus_msg.cmd = iob_pkg::OK;
		else
			bus_msg.cmd = iob_pkg::PE;
		bus_msg.qb = bus.qb;
		bus_msg.pn = bus.pn;
		bus_msg.nb = bus.nb;
		bus_msg.ad = bus.ad;
		bus_msg.dt = bus.dt;
	end

	always_comb begin
		case (idx)
			3'd0: tx_byte = {msg.is_req, 3'b000, msg.cmd};
			3'd1: tx_byte = {msg.qb, msg.pn, 2'b00, msg.nb};
			3'd2: tx_byte = msg.ad[15:8];
			3'd3: tx_byte = msg.ad[7:0];
			3'd4: tx_byte = msg.dt[15:8];
			default: tx_byte = msg.dt[7:0];
		endcase
	end

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			state <= TX_IDLE;
			idx <= '0;
			busy <= 1'b0;
			tx_send <= 1'b0;
		end else begin
			tx_send <= 1'b0;
			case (state)
				TX_IDLE: if (send) begin
					busy <= 1'b1;
					idx <= '0;
					state <= TX_LOAD;
				end
				TX_LOAD: begin
					tx_send <= 1'b1;
					state <= TX_WAIT;
				end
				default: if (!tx_send && !tx_busy) begin // uart done with byte
					if (idx == 3'(iob_pkg::FRAME_BYTES - 1)) begin
						busy <= 1'b0;
						state <= TX_IDLE;
					end else begin
						idx <= idx + 3'd1;
						state <= TX_LOAD;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (send && state == TX_IDLE)
			msg <= bus_msg; // bus snapshot
	end

endmodule

// ==== logic/uart_link.sv ====
`timescale 1ns/100ps

module uart_link #(
	parameter int CLKS_PER_BIT = 8
) (
	input  logic       clk_sys,
	input  logic       arst_n,
	input  logic       rxd,
	output logic       txd,
	input  logic [7:0] tx_byte,
	input  logic       tx_send,
	output logic       tx_busy,
	output logic [7:0] rx_byte,
	output logic       rx_valid
);

	localparam int CW = $clog2(CLKS_PER_BIT);

	logic [9:0]    tx_shift; // stop, data, start
	logic [3:0]    tx_bit;
	logic [CW-1:0] tx_clk;

	logic          rx_meta;
	logic          rx_sync;
	logic          rx_active;
	logic [3:0]    rx_bit;
	logic [CW-1:0] rx_clk;
	logic [7:0]    rx_shift;

	assign txd = tx_shift[0]; // idles high, shift reg fills with ones
	assign rx_byte = rx_shift;

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			tx_shift <= '1;
			tx_bit <= '0;
			tx_clk <= '0;
			tx_busy <= 1'b0;
		end else if (!tx_busy) begin
			if (tx_send) begin
				tx_shift <= {1'b1, tx_byte, 1'b0};
				tx_bit <= '0;
				tx_clk <= '0;
				tx_busy <= 1'b1;
			end
		end else if (tx_clk == CW'(CLKS_PER_BIT - 1)) begin
			tx_clk <= '0;
			if (tx_bit == 4'd9) begin
				tx_busy <= 1'b0; // stop bit done
			end else begin
				tx_bit <= tx_bit + 4'd1;
				tx_shift <= {1'b1, tx_shift[9:1]};
			end
		end else begin
			tx_clk <= tx_clk + CW'(1);
		end
	end

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end else begin
			rx_meta <= rxd;
			rx_sync <= rx_meta;
		end
	end

	// receiver counts down to the middle of each bit
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			rx_active <= 1'b0;
			rx_bit <= '0;
			rx_clk <= '0;
			rx_valid <= 1'b0;
		end else begin
			rx_valid <= 1'b0;
			if (!rx_active) begin
				if (!rx_sync) begin // start edge
					rx_active <= 1'b1;
					rx_bit <= '0;
					rx_clk <= CW'(CLKS_PER_BIT / 2 - 1);
				end
			end else if (rx_clk != '0) begin
				rx_clk <= rx_clk - CW'(1);
			end else begin
				rx_clk <= CW'(CLKS_PER_BIT - 1);
				rx_bit <= rx_bit + 4'd1;
				if (rx_bit == 4'd0 && rx_sync)
					rx_active <= 1'b0; // glitch, not a start bit
				if (rx_bit == 4'd9) begin
					rx_active <= 1'b0;
					rx_valid <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (rx_active && rx_clk == '0 && rx_bit >= 4'd1 && rx_bit <= 4'd8)
			rx_shift <= {rx_sync, rx_shift[7:1]}; // lsb first
	end

endmodule

// ==== run.sh ====
#!/bin/sh
# build with Verilator, run, then look for the pass line in the output
cd "$(dirname "$0")" &&
verilator --binary --timing --top-module tb_iobus -f list.f &&
./obj_dir/Vtb_iobus | tee /dev/stderr | grep "^Testbench passed$" > /dev/null &&
echo "run.sh: simulation ok" ||
{ echo "run.sh: simulation not ok"; exit 1; }
